//--- Makefile
SRCS := $(wildcard logic/*.sv bench/*.sv)

obj_dir/Vparc_dpath_tb: compile.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module parc_dpath_tb -f compile.f

.PHONY: run clean

run: obj_dir/Vparc_dpath_tb
	./obj_dir/Vparc_dpath_tb | tee /dev/stderr | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir

//--- bench/parc_dpath_tb.sv
/*
 * Testbench for the seven-stage datapath
 * Reference pipeline model, LFSR stimulus, immediate assertions, watchdog
 */

`timescale 1ns/1ps

module parc_dpath_tb;

  localparam dpath_pkg::word_t reset_vec = 32'h0008_0000;
  localparam int num_tests = 5;
  localparam int cycles_per_test = 60;

  logic clk;
  logic reset;
  dpath_pkg::word_t imemreq_addr, dmemreq_addr, dmemreq_data, dmemresp_data, inst_d;
  dpath_pkg::word_t proc2cop_data_w;
  logic [1:0] pc_mux_sel_p, op0_mux_sel_d;
  logic [2:0] op0_byp_sel_d, op1_byp_sel_d, op1_mux_sel_d, dmemresp_sel_m;
  logic [3:0] alu_fn_x;
  logic [4:0] rf_waddr_w;
  logic dmemresp_queue_en_m, dmemresp_queue_val_m, wb_mux_sel_m, rf_wen_w;
  logic stall_f, stall_d, stall_x, stall_m, stall_pm, stall_pw, stall_w;
  logic branch_cond_eq_x, branch_cond_zero_x, branch_cond_neg_x;

  // Reference state, one entry per stage
  dpath_pkg::word_t x_m, m_m, pm_m, pw_m, w_m, op0_xm, op1_xm, wd_xm, q_m;
  dpath_pkg::word_t rf_m [32];
  dpath_pkg::word_t pc_f_m, pc4d_m, exp_addr, v;
  logic [31:0] lfsr, r;
  logic [3:0] fns [5];
  string test_name;

  parc_dpath #(.RESET_VECTOR(reset_vec)) dut (.*);

  initial begin
    clk = 0;
    forever #5 clk = ~clk;
  end

  // Watchdog
  initial begin
    #((num_tests * cycles_per_test + 50) * 10);
    $display("Run timed out before all tests completed");
    $display("Simulation finished: FAIL");
    $fatal(1, "watchdog expired");
  end

  // Galois LFSR, one step per random bit
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      val = {val[30:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
  endtask

  function automatic dpath_pkg::word_t sext16(input logic [15:0] imm);
    return {{16{imm[15]}}, imm};
  endfunction

  // Expected ALU result from the function table
  function automatic dpath_pkg::word_t alu_ref(input logic [3:0] fn, input dpath_pkg::word_t a,
                                               input dpath_pkg::word_t b);
    case (fn)
      dpath_pkg::alu_add:   return a + b;
      dpath_pkg::alu_sub:   return a - b;
      dpath_pkg::alu_or:    return a | b;
      dpath_pkg::alu_xor:   return a ^ b;
      dpath_pkg::alu_slt:   return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      dpath_pkg::alu_pass0: return a;
      default:              return b;
    endcase
  endfunction

  function automatic dpath_pkg::word_t load_ref(input logic [2:0] sel, input dpath_pkg::word_t d);
    case (sel)
      dpath_pkg::ld_lb:  return {{24{d[7]}}, d[7:0]};
      dpath_pkg::ld_lbu: return {24'b0, d[7:0]};
      dpath_pkg::ld_lh:  return {{16{d[15]}}, d[15:0]};
      dpath_pkg::ld_lhu: return {16'b0, d[15:0]};
      default:           return d;
    endcase
  endfunction

  task automatic check(input string what, input dpath_pkg::word_t exp, input dpath_pkg::word_t act);
    assert (act === exp) else begin
      $display("** Error %s/%s: expected %h, actual %h", test_name, what, exp, act);
      $display("Simulation finished: FAIL");
      $fatal(1, "check failed");
    end
  endtask

  // D-stage select inputs
  task automatic set_d(input logic [1:0] s0, input logic [2:0] b0, input logic [2:0] s1,
                       input dpath_pkg::word_t inst);
    op0_mux_sel_d = s0;
    op0_byp_sel_d = b0;
    op1_mux_sel_d = s1;
    inst_d = inst;
  endtask

  // ------------------------------------------------------------
  // One pipeline cycle, fn applies to the X instruction
  // ------------------------------------------------------------
  task automatic cycle(input logic [3:0] fn, input int src, input dpath_pkg::word_t d0,
                       input dpath_pkg::word_t d1);
    dpath_pkg::word_t adj;
    dpath_pkg::word_t pm_in;
    dpath_pkg::word_t wd;
    alu_fn_x = fn;
    x_m = alu_ref(fn, op0_xm, op1_xm);
    adj = load_ref(dmemresp_sel_m, dmemresp_data);
    pm_in = wb_mux_sel_m ? (dmemresp_queue_val_m ? q_m : adj) : m_m;
    // Store data is rt, op1 bypass stays on the regfile
    wd = rf_m[inst_d[20:16]];
    // Bypass source seen by op0 in D
    case (src)
      0: d0 = rf_m[inst_d[25:21]];
      1: d0 = x_m;
      2: d0 = pm_in;
      3: d0 = pm_m;
      4: d0 = pw_m;
      5: d0 = w_m;
      default: ;
    endcase
    #1;
    check("dmemreq_addr", x_m, dmemreq_addr);
    check("dmemreq_data", wd_xm, dmemreq_data);
    check("proc2cop_data_w", w_m, proc2cop_data_w);
    check("branch_cond_eq_x", {31'b0, x_m == '0}, {31'b0, branch_cond_eq_x});
    check("branch_cond_zero_x", {31'b0, op0_xm == '0}, {31'b0, branch_cond_zero_x});
    check("branch_cond_neg_x", {31'b0, op0_xm[31]}, {31'b0, branch_cond_neg_x});
    @(posedge clk);
    if (rf_wen_w && rf_waddr_w != '0) rf_m[rf_waddr_w] = w_m;
    if (dmemresp_queue_en_m) q_m = adj;
    w_m = pw_m;
    pw_m = pm_m;
    pm_m = pm_in;
    m_m = x_m;
    op0_xm = d0;
    op1_xm = d1;
    wd_xm = wd;
    @(negedge clk);
  endtask

  initial begin
    lfsr = 32'h1efb48ea;
    reset = 1;
    {pc_mux_sel_p, op0_byp_sel_d, op1_byp_sel_d, alu_fn_x, dmemresp_sel_m} = '0;
    {dmemresp_queue_en_m, dmemresp_queue_val_m, wb_mux_sel_m, rf_wen_w, rf_waddr_w} = '0;
    {stall_f, stall_d, stall_x, stall_m, stall_pm, stall_pw, stall_w} = '0;
    dmemresp_data = '0;
    set_d(dpath_pkg::op0_zero, dpath_pkg::byp_rf, dpath_pkg::op1_zero, '0);
    {x_m, m_m, pm_m, pw_m, w_m, op0_xm, op1_xm, wd_xm, q_m} = '0;
    foreach (rf_m[i]) rf_m[i] = '0;

    // Fetch
    test_name = "fetch";
    repeat (4) @(posedge clk);
    @(negedge clk);
    check("imemreq_addr in reset", reset_vec, imemreq_addr);
    reset = 0;
    #1 check("flags after reset", 32'd3,
             {29'b0, branch_cond_neg_x, branch_cond_zero_x, branch_cond_eq_x});
    check("dmemreq_addr after reset", '0, dmemreq_addr);
    check("dmemreq_data after reset", '0, dmemreq_data);
    pc_f_m = reset_vec;
    pc4d_m = '0;
    for (int i = 0; i < 6; i++) begin
      stall_f = (i == 3 || i == 4);
      #1 check("imemreq_addr plus4", pc_f_m + 4, imemreq_addr);
      @(posedge clk);
      pc4d_m = pc_f_m + 4;
      if (!stall_f) pc_f_m = pc_f_m + 4;
      @(negedge clk);
    end
    stall_f = 0;
    rand_bits(26, r);
    pc_mux_sel_p = dpath_pkg::pcsel_jump;
    // X holds while the jump word sits in D
    stall_x = 1;
    inst_d = {6'b0, r[25:0]};
    exp_addr = {pc4d_m[31:28], r[25:0], 2'b00};
    #1 check("imemreq_addr jump", exp_addr, imemreq_addr);
    @(negedge clk);
    pc_mux_sel_p = dpath_pkg::pcsel_plus4;
    stall_x = 0;
    #1 check("imemreq_addr after jump", exp_addr + 4, imemreq_addr);

    // ALU through writeback
    test_name = "alu_writeback";
    fns = '{dpath_pkg::alu_add, dpath_pkg::alu_sub, dpath_pkg::alu_or, dpath_pkg::alu_xor,
            dpath_pkg::alu_slt};
    for (int i = 0; i < 10; i++) begin
      rand_bits(16, r);
      if (i < 5) set_d(dpath_pkg::op0_zero, 0, dpath_pkg::op1_sext, {16'b0, r[15:0]});
      else set_d(dpath_pkg::op0_zero, 0, dpath_pkg::op1_zero, '0);
      cycle((i == 0 || i > 5) ? dpath_pkg::alu_add : fns[i-1], -1, '0,
            (i < 5) ? sext16(r[15:0]) : '0);
    end

    // Register file and bypass
    test_name = "regfile_bypass";
    rand_bits(16, r);
    v = sext16(r[15:0]);
    set_d(dpath_pkg::op0_zero, 0, dpath_pkg::op1_sext, {16'b0, r[15:0]});
    cycle(dpath_pkg::alu_add, -1, '0, v);
    set_d(dpath_pkg::op0_zero, 0, dpath_pkg::op1_zero, '0);
    repeat (4) cycle(dpath_pkg::alu_add, -1, '0, '0);
    rand_bits(5, r);
    rf_waddr_w = (r[4:0] == '0) ? 5'd1 : r[4:0];
    rf_wen_w = 1;
    cycle(dpath_pkg::alu_add, -1, '0, '0);
    rf_wen_w = 0;
    // rs and rt both name the written register
    set_d(dpath_pkg::op0_byp, dpath_pkg::byp_rf, dpath_pkg::op1_zero,
          {6'b0, rf_waddr_w, rf_waddr_w, 16'b0});
    cycle(dpath_pkg::alu_add, 0, '0, '0);
    for (int i = 0; i < 4; i++) begin
      rand_bits(16, r);
      set_d(dpath_pkg::op0_zero, 0, dpath_pkg::op1_sext, {16'b0, r[15:0]});
      cycle(dpath_pkg::alu_add, -1, '0, sext16(r[15:0]));
    end
    for (int s = 1; s <= 5; s++) begin
      set_d(dpath_pkg::op0_byp, s[2:0], dpath_pkg::op1_zero, '0);
      cycle((s == 1) ? dpath_pkg::alu_add : dpath_pkg::alu_pass0, s, '0, '0);
    end

    // Load adjustment and response holding register
    test_name = "load_adjust";
    set_d(dpath_pkg::op0_zero, 0, dpath_pkg::op1_zero, '0);
    wb_mux_sel_m = 1;
    for (int s = 0; s < 5; s++) begin
      rand_bits(32, r);
      dmemresp_data = r;
      dmemresp_sel_m = s[2:0];
      cycle((s == 0) ? dpath_pkg::alu_pass0 : dpath_pkg::alu_add, -1, '0, '0);
    end
    rand_bits(32, r);
    dmemresp_data = r;
    dmemresp_sel_m = dpath_pkg::ld_lbu;
    dmemresp_queue_en_m = 1;
    cycle(dpath_pkg::alu_add, -1, '0, '0);
    rand_bits(32, r);
    dmemresp_data = r;
    dmemresp_sel_m = dpath_pkg::ld_word;
    dmemresp_queue_en_m = 0;
    dmemresp_queue_val_m = 1;
    cycle(dpath_pkg::alu_add, -1, '0, '0);
    dmemresp_queue_val_m = 0;
    wb_mux_sel_m = 0;
    repeat (4) cycle(dpath_pkg::alu_add, -1, '0, '0);

    // Branch flags on random operands, then an equal pair
    test_name = "branch_flags";
    for (int i = 0; i < 4; i++) begin
      rand_bits(16, r);
      set_d(dpath_pkg::op0_zero, 0, dpath_pkg::op1_sext, {16'b0, r[15:0]});
      cycle(dpath_pkg::alu_sub, -1, '0, sext16(r[15:0]));
      rand_bits(16, r);
      set_d(dpath_pkg::op0_byp, dpath_pkg::byp_x, dpath_pkg::op1_sext, {16'b0, r[15:0]});
      cycle(dpath_pkg::alu_sub, 1, '0, sext16(r[15:0]));
    end
    set_d(dpath_pkg::op0_sixteen, 0, dpath_pkg::op1_sext, 32'd16);
    cycle(dpath_pkg::alu_sub, -1, 32'd16, 32'd16);
    set_d(dpath_pkg::op0_zero, 0, dpath_pkg::op1_zero, '0);
    repeat (2) cycle(dpath_pkg::alu_sub, -1, '0, '0);

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

//--- compile.f
logic/dpath_pkg.sv
logic/dpath_ifs.sv
logic/fetch_unit.sv
logic/decode_unit.sv
logic/reg_file.sv
logic/execute_unit.sv
logic/mem_wb_unit.sv
logic/parc_dpath.sv
bench/parc_dpath_tb.sv

//--- logic/decode_unit.sv
/*
 * Instruction field split, immediate extension, branch and jump targets
 * Bypass muxes, operand muxes and the X-stage registers
 */

`timescale 1ns/1ps

module decode_unit (
  input  logic                clk,
  input  logic                reset,
  pipe_stall_if.decode        stall,
  byp_bus_if.sink_decode      byp,
  input  dpath_pkg::word_t    inst_d,
  input  dpath_pkg::word_t    pc_plus4_d,
  input  dpath_pkg::byp_sel_e op0_byp_sel_d,
  input  dpath_pkg::byp_sel_e op1_byp_sel_d,
  input  dpath_pkg::op0_sel_e op0_mux_sel_d,
  input  dpath_pkg::op1_sel_e op1_mux_sel_d,
  output dpath_pkg::reg_idx_t rf_raddr0,
  output dpath_pkg::reg_idx_t rf_raddr1,
  input  dpath_pkg::word_t    rf_rdata0,
  input  dpath_pkg::word_t    rf_rdata1,
  output dpath_pkg::word_t    jump_targ_d,
  output dpath_pkg::word_t    jumpreg_targ_d,
  output dpath_pkg::word_t    branch_targ_x,
  output dpath_pkg::word_t    op0_x,
  output dpath_pkg::word_t    op1_x,
  output dpath_pkg::word_t    wdata_x
);

  dpath_pkg::word_t imm_sext_d;
  dpath_pkg::word_t imm_zext_d;
  dpath_pkg::word_t shamt_d;
  dpath_pkg::word_t branch_targ_d;
  dpath_pkg::word_t op0_byp_d;
  dpath_pkg::word_t op1_byp_d;
  dpath_pkg::word_t op0_d;
  dpath_pkg::word_t op1_d;

  // rs and rt drive the regfile read ports
  assign rf_raddr0 = inst_d[25:21];
  assign rf_raddr1 = inst_d[20:16];

  assign imm_sext_d = {{16{inst_d[15]}}, inst_d[15:0]};
  assign imm_zext_d = {16'b0, inst_d[15:0]};
  assign shamt_d    = {27'b0, inst_d[10:6]};

  // Branch offset is in words
  assign branch_targ_d  = pc_plus4_d + (imm_sext_d << 2);
  assign jump_targ_d    = {pc_plus4_d[31:28], inst_d[25:0], 2'b00};
  assign jumpreg_targ_d = op0_byp_d;

  // ----------------------------------------------------------
  // Bypass and operand muxes
  // ----------------------------------------------------------

  always_comb begin
    unique case (op0_byp_sel_d)
      dpath_pkg::byp_x:  op0_byp_d = byp.x;
      dpath_pkg::byp_m:  op0_byp_d = byp.m;
      dpath_pkg::byp_pm: op0_byp_d = byp.pm;
      dpath_pkg::byp_pw: op0_byp_d = byp.pw;
      dpath_pkg::byp_w:  op0_byp_d = byp.w;
      default:           op0_byp_d = rf_rdata0;
    endcase
    unique case (op1_byp_sel_d)
      dpath_pkg::byp_x:  op1_byp_d = byp.x;
      dpath_pkg::byp_m:  op1_byp_d = byp.m;
      dpath_pkg::byp_pm: op1_byp_d = byp.pm;
      dpath_pkg::byp_pw: op1_byp_d = byp.pw;
      dpath_pkg::byp_w:  op1_byp_d = byp.w;
      default:           op1_byp_d = rf_rdata1;
    endcase
  end

  always_comb begin
    unique case (op0_mux_sel_d)
      dpath_pkg::op0_shamt:   op0_d = shamt_d;
      dpath_pkg::op0_sixteen: op0_d = 32'd16;
      dpath_pkg::op0_zero:    op0_d = '0;
      default:                op0_d = op0_byp_d;
    endcase
    unique case (op1_mux_sel_d)
      dpath_pkg::op1_zext: op1_d = imm_zext_d;
      dpath_pkg::op1_sext: op1_d = imm_sext_d;
      dpath_pkg::op1_pc4:  op1_d = pc_plus4_d;
      dpath_pkg::op1_zero: op1_d = '0;
      default:             op1_d = op1_byp_d;
    endcase
  end

  // X <- D, store data is the bypassed rt
  always_ff @(posedge clk) begin
    if (reset) begin
      branch_targ_x <= '0;
      op0_x         <= '0;
      op1_x         <= '0;
      wdata_x       <= '0;
    end else if (!stall.x) begin
      branch_targ_x <= branch_targ_d;
      op0_x         <= op0_d;
      op1_x         <= op1_d;
      wdata_x       <= op1_byp_d;
    end
  end

  // Controller only issues defined select codes
  sel_defined: assert property (@(posedge clk) disable iff (reset)
    op1_mux_sel_d <= dpath_pkg::op1_zero && op0_byp_sel_d <= dpath_pkg::byp_w &&
    op1_byp_sel_d <= dpath_pkg::byp_w);

endmodule

//--- logic/dpath_ifs.sv
/*
 * Per-stage stall bundle
 * Bypass value bus from the later stages back to decode
 */

`timescale 1ns/1ps

// Stall levels, one per stage
interface pipe_stall_if;
  logic f;
  logic d;
  logic x;
  logic m;
  logic pm;
  logic pw;
  logic w;

  modport fetch   (input f, d);
  modport decode  (input x);
  modport execute (input m);
  modport memwb   (input pm, pw, w);
endinterface

// Bypass values, X comes straight off the ALU
interface byp_bus_if;
  dpath_pkg::word_t x;
  dpath_pkg::word_t m;
  dpath_pkg::word_t pm;
  dpath_pkg::word_t pw;
  dpath_pkg::word_t w;

  modport src_execute (output x);
  modport src_memwb   (output m, pm, pw, w);
  modport sink_decode (input x, m, pm, pw, w);
endinterface

//--- logic/dpath_pkg.sv
/*
 * Shared datapath widths and word types
 * Mux select encodings and ALU function codes
 */

package dpath_pkg;

  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;

  typedef logic [xlen-1:0]       word_t;
  typedef logic [reg_addr_w-1:0] reg_idx_t;

  // Next PC source
  typedef enum logic [1:0] {
    pcsel_plus4, pcsel_branch, pcsel_jump, pcsel_jumpreg
  } pc_sel_e;

  // Bypass source, regfile read is the default
  typedef enum logic [2:0] {
    byp_rf, byp_x, byp_m, byp_pm, byp_pw, byp_w
  } byp_sel_e;

  typedef enum logic [1:0] {
    op0_byp, op0_shamt, op0_sixteen, op0_zero
  } op0_sel_e;

  typedef enum logic [2:0] {
    op1_byp, op1_zext, op1_sext, op1_pc4, op1_zero
  } op1_sel_e;

  // ALU functions, shifts take the amount from op0
  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_or, alu_slt, alu_sltu, alu_and,
    alu_xor, alu_nor, alu_srl, alu_sra, alu_pass0, alu_pass1
  } alu_fn_e;

  // Load subword adjustment
  typedef enum logic [2:0] {
    ld_word, ld_lb, ld_lbu, ld_lh, ld_lhu
  } ld_sel_e;

endpackage

//--- logic/execute_unit.sv
/*
 * ALU and branch condition flags
 * Data memory request and the M-stage result register
 */

`timescale 1ns/1ps

module execute_unit (
  input  logic               clk,
  input  logic               reset,
  pipe_stall_if.execute      stall,
  byp_bus_if.src_execute     byp,
  input  dpath_pkg::word_t   op0_x,
  input  dpath_pkg::word_t   op1_x,
  input  dpath_pkg::word_t   wdata_x,
  input  dpath_pkg::alu_fn_e alu_fn_x,
  output logic               branch_cond_eq_x,
  output logic               branch_cond_zero_x,
  output logic               branch_cond_neg_x,
  output dpath_pkg::word_t   dmemreq_addr,
  output dpath_pkg::word_t   dmemreq_data,
  output dpath_pkg::word_t   alu_out_m
);

  dpath_pkg::word_t alu_out_x;

  // ----------------------------------------------------------
  // ALU
  // ----------------------------------------------------------

  // Shift amount in op0[4:0], shifted value in op1
  always_comb begin
    unique case (alu_fn_x)
      dpath_pkg::alu_sub:   alu_out_x = op0_x - op1_x;
      dpath_pkg::alu_sll:   alu_out_x = op1_x << op0_x[4:0];
      dpath_pkg::alu_or:    alu_out_x = op0_x | op1_x;
      dpath_pkg::alu_slt:   alu_out_x = {31'b0, $signed(op0_x) < $signed(op1_x)};
      dpath_pkg::alu_sltu:  alu_out_x = {31'b0, op0_x < op1_x};
      dpath_pkg::alu_and:   alu_out_x = op0_x & op1_x;
      dpath_pkg::alu_xor:   alu_out_x = op0_x ^ op1_x;
      dpath_pkg::alu_nor:   alu_out_x = ~(op0_x | op1_x);
      dpath_pkg::alu_srl:   alu_out_x = op1_x >> op0_x[4:0];
      dpath_pkg::alu_sra:   alu_out_x = $signed(op1_x) >>> op0_x[4:0];
      dpath_pkg::alu_pass0: alu_out_x = op0_x;
      dpath_pkg::alu_pass1: alu_out_x = op1_x;
      default:              alu_out_x = op0_x + op1_x;
    endcase
  end

  // Branch flags for the controller
  assign branch_cond_eq_x   = (alu_out_x == '0);
  assign branch_cond_zero_x = (op0_x == '0);
  assign branch_cond_neg_x  = op0_x[31];

  // Request leaves in X, response returns in M
  assign dmemreq_addr = alu_out_x;
  assign dmemreq_data = wdata_x;
  assign byp.x        = alu_out_x;

  // M <- X
  always_ff @(posedge clk) begin
    if (reset) begin
      alu_out_m <= '0;
    end else if (!stall.m) begin
      alu_out_m <= alu_out_x;
    end
  end

  alu_fn_defined: assert property (@(posedge clk) disable iff (reset)
    alu_fn_x <= dpath_pkg::alu_pass1);

endmodule

//--- logic/fetch_unit.sv
/*
 * Next PC select, F-stage PC register and incrementer
 * D-stage pc plus 4 register
 */

`timescale 1ns/1ps

module fetch_unit #(
  parameter dpath_pkg::word_t RESET_VECTOR = 32'h0008_0000
) (
  input  logic               clk,
  input  logic               reset,
  pipe_stall_if.fetch        stall,
  input  dpath_pkg::pc_sel_e pc_mux_sel_p,
  input  dpath_pkg::word_t   branch_targ_x,
  input  dpath_pkg::word_t   jump_targ_d,
  input  dpath_pkg::word_t   jumpreg_targ_d,
  output dpath_pkg::word_t   imemreq_addr,
  output dpath_pkg::word_t   pc_plus4_d
);

  dpath_pkg::word_t pc_f;
  dpath_pkg::word_t pc_plus4_f;
  dpath_pkg::word_t pc_mux_out_p;

  // ----------------------------------------------------------
  // P stage
  // ----------------------------------------------------------

  // Targets come back from D and X
  always_comb begin
    unique case (pc_mux_sel_p)
      dpath_pkg::pcsel_branch:  pc_mux_out_p = branch_targ_x;
      dpath_pkg::pcsel_jump:    pc_mux_out_p = jump_targ_d;
      dpath_pkg::pcsel_jumpreg: pc_mux_out_p = jumpreg_targ_d;
      default:                  pc_mux_out_p = pc_plus4_f;
    endcase
  end

  // Early imem request, reset vector while in reset
  assign imemreq_addr = reset ? RESET_VECTOR : pc_mux_out_p;

  // ----------------------------------------------------------
  // F stage
  // ----------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      pc_f <= RESET_VECTOR;
    end else if (!stall.f) begin
      pc_f <= pc_mux_out_p;
    end
  end

  assign pc_plus4_f = pc_f + 32'd4;

  // D <- F
  always_ff @(posedge clk) begin
    if (reset) begin
      pc_plus4_d <= '0;
    end else if (!stall.d) begin
      pc_plus4_d <= pc_plus4_f;
    end
  end

  // Fetch address never loses word alignment
  pc_aligned: assert property (@(posedge clk) disable iff (reset) pc_f[1:0] == 2'b00);

endmodule

//--- logic/mem_wb_unit.sv
/*
 * Load subword adjustment and one-entry response holding register
 * Post-memory select, PM, PW and W registers
 */

`timescale 1ns/1ps

module mem_wb_unit (
  input  logic               clk,
  input  logic               reset,
  pipe_stall_if.memwb        stall,
  byp_bus_if.src_memwb       byp,
  input  dpath_pkg::word_t   alu_out_m,
  input  dpath_pkg::word_t   dmemresp_data,
  input  dpath_pkg::ld_sel_e dmemresp_sel_m,
  input  logic               dmemresp_queue_en_m,
  input  logic               dmemresp_queue_val_m,
  input  logic               wb_mux_sel_m,
  output dpath_pkg::word_t   wb_data_w
);

  dpath_pkg::word_t resp_adj_m;
  dpath_pkg::word_t resp_queue_m;
  dpath_pkg::word_t resp_out_m;
  dpath_pkg::word_t pm_out_m;
  dpath_pkg::word_t result_pm;
  dpath_pkg::word_t result_pw;

  // ----------------------------------------------------------
  // M stage
  // ----------------------------------------------------------

  // Byte and half loads, signed or unsigned
  always_comb begin
    unique case (dmemresp_sel_m)
      dpath_pkg::ld_lb:  resp_adj_m = {{24{dmemresp_data[7]}}, dmemresp_data[7:0]};
      dpath_pkg::ld_lbu: resp_adj_m = {24'b0, dmemresp_data[7:0]};
      dpath_pkg::ld_lh:  resp_adj_m = {{16{dmemresp_data[15]}}, dmemresp_data[15:0]};
      dpath_pkg::ld_lhu: resp_adj_m = {16'b0, dmemresp_data[15:0]};
      default:           resp_adj_m = dmemresp_data;
    endcase
  end

  // Holds a response that arrived while M was stalled
  always_ff @(posedge clk) begin
    if (reset) begin
      resp_queue_m <= '0;
    end else if (dmemresp_queue_en_m) begin
      resp_queue_m <= resp_adj_m;
    end
  end

  assign resp_out_m = dmemresp_queue_val_m ? resp_queue_m : resp_adj_m;

  // Post-memory select, load data or ALU result
  assign pm_out_m = wb_mux_sel_m ? resp_out_m : alu_out_m;

  // ----------------------------------------------------------
  // PM, PW and W registers
  // ----------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      result_pm <= '0;
      result_pw <= '0;
      wb_data_w <= '0;
    end else begin
      if (!stall.pm) begin
        result_pm <= pm_out_m;
      end
      if (!stall.pw) begin
        result_pw <= result_pm;
      end
      if (!stall.w) begin
        wb_data_w <= result_pw;
      end
    end
  end

  // Every stage feeds the decode bypass
  assign byp.m  = pm_out_m;
  assign byp.pm = result_pm;
  assign byp.pw = result_pw;
  assign byp.w  = wb_data_w;

  // Only checked when the load data is actually selected
  ld_sel_defined: assert property (@(posedge clk) disable iff (reset)
    wb_mux_sel_m |-> dmemresp_sel_m <= dpath_pkg::ld_lhu);

endmodule

//--- logic/parc_dpath.sv
/*
 * Seven-stage integer datapath top level
 * Stall and bypass interfaces, unit instances
 */

`timescale 1ns/1ps

module parc_dpath #(
  parameter dpath_pkg::word_t RESET_VECTOR = 32'h0008_0000
) (
  input  logic             clk,
  input  logic             reset,
  output dpath_pkg::word_t imemreq_addr,
  output dpath_pkg::word_t dmemreq_addr,
  output dpath_pkg::word_t dmemreq_data,
  input  dpath_pkg::word_t dmemresp_data,
  // Controller selects
  input  logic [1:0]       pc_mux_sel_p,
  input  dpath_pkg::word_t inst_d,
  input  logic [2:0]       op0_byp_sel_d,
  input  logic [2:0]       op1_byp_sel_d,
  input  logic [1:0]       op0_mux_sel_d,
  input  logic [2:0]       op1_mux_sel_d,
  input  logic [3:0]       alu_fn_x,
  input  logic [2:0]       dmemresp_sel_m,
  input  logic             dmemresp_queue_en_m,
  input  logic             dmemresp_queue_val_m,
  input  logic             wb_mux_sel_m,
  input  logic             rf_wen_w,
  input  logic [4:0]       rf_waddr_w,
  // Per-stage stalls
  input  logic             stall_f,
  input  logic             stall_d,
  input  logic             stall_x,
  input  logic             stall_m,
  input  logic             stall_pm,
  input  logic             stall_pw,
  input  logic             stall_w,
  // Back to the controller
  output logic             branch_cond_eq_x,
  output logic             branch_cond_zero_x,
  output logic             branch_cond_neg_x,
  output dpath_pkg::word_t proc2cop_data_w
);

  dpath_pkg::word_t    pc_plus4_d;
  dpath_pkg::word_t    jump_targ_d;
  dpath_pkg::word_t    jumpreg_targ_d;
  dpath_pkg::word_t    branch_targ_x;
  dpath_pkg::reg_idx_t rf_raddr0;
  dpath_pkg::reg_idx_t rf_raddr1;
  dpath_pkg::word_t    rf_rdata0;
  dpath_pkg::word_t    rf_rdata1;
  dpath_pkg::word_t    op0_x;
  dpath_pkg::word_t    op1_x;
  dpath_pkg::word_t    wdata_x;
  dpath_pkg::word_t    alu_out_m;
  dpath_pkg::word_t    wb_data_w;

  pipe_stall_if stall_if ();
  byp_bus_if    byp_bus ();

  assign stall_if.f  = stall_f;
  assign stall_if.d  = stall_d;
  assign stall_if.x  = stall_x;
  assign stall_if.m  = stall_m;
  assign stall_if.pm = stall_pm;
  assign stall_if.pw = stall_pw;
  assign stall_if.w  = stall_w;

  fetch_unit #(.RESET_VECTOR(RESET_VECTOR)) fetch (
    .clk(clk), .reset(reset), .stall(stall_if.fetch),
    .pc_mux_sel_p(dpath_pkg::pc_sel_e'(pc_mux_sel_p)),
    .branch_targ_x(branch_targ_x), .jump_targ_d(jump_targ_d),
    .jumpreg_targ_d(jumpreg_targ_d), .imemreq_addr(imemreq_addr),
    .pc_plus4_d(pc_plus4_d)
  );

  decode_unit decode (
    .clk(clk), .reset(reset), .stall(stall_if.decode), .byp(byp_bus.sink_decode),
    .inst_d(inst_d), .pc_plus4_d(pc_plus4_d),
    .op0_byp_sel_d(dpath_pkg::byp_sel_e'(op0_byp_sel_d)),
    .op1_byp_sel_d(dpath_pkg::byp_sel_e'(op1_byp_sel_d)),
    .op0_mux_sel_d(dpath_pkg::op0_sel_e'(op0_mux_sel_d)),
    .op1_mux_sel_d(dpath_pkg::op1_sel_e'(op1_mux_sel_d)),
    .rf_raddr0(rf_raddr0), .rf_raddr1(rf_raddr1),
    .rf_rdata0(rf_rdata0), .rf_rdata1(rf_rdata1),
    .jump_targ_d(jump_targ_d), .jumpreg_targ_d(jumpreg_targ_d),
    .branch_targ_x(branch_targ_x), .op0_x(op0_x), .op1_x(op1_x), .wdata_x(wdata_x)
  );

  // Written from W, same word as the coprocessor output
  reg_file rfile (
    .clk(clk), .raddr0(rf_raddr0), .raddr1(rf_raddr1),
    .rdata0(rf_rdata0), .rdata1(rf_rdata1),
    .wen(rf_wen_w), .waddr(rf_waddr_w), .wdata(wb_data_w)
  );

  execute_unit execute (
    .clk(clk), .reset(reset), .stall(stall_if.execute), .byp(byp_bus.src_execute),
    .op0_x(op0_x), .op1_x(op1_x), .wdata_x(wdata_x),
    .alu_fn_x(dpath_pkg::alu_fn_e'(alu_fn_x)),
    .branch_cond_eq_x(branch_cond_eq_x), .branch_cond_zero_x(branch_cond_zero_x),
    .branch_cond_neg_x(branch_cond_neg_x),
    .dmemreq_addr(dmemreq_addr), .dmemreq_data(dmemreq_data), .alu_out_m(alu_out_m)
  );

  mem_wb_unit memwb (
    .clk(clk), .reset(reset), .stall(stall_if.memwb), .byp(byp_bus.src_memwb),
    .alu_out_m(alu_out_m), .dmemresp_data(dmemresp_data),
    .dmemresp_sel_m(dpath_pkg::ld_sel_e'(dmemresp_sel_m)),
    .dmemresp_queue_en_m(dmemresp_queue_en_m),
    .dmemresp_queue_val_m(dmemresp_queue_val_m),
    .wb_mux_sel_m(wb_mux_sel_m), .wb_data_w(wb_data_w)
  );

  assign proc2cop_data_w = wb_data_w;

endmodule

//--- logic/reg_file.sv
/*
 * 32-entry register file, two async reads and one sync write
 */

`timescale 1ns/1ps

module reg_file (
  input  logic                clk,
  input  dpath_pkg::reg_idx_t raddr0,
  input  dpath_pkg::reg_idx_t raddr1,
  output dpath_pkg::word_t    rdata0,
  output dpath_pkg::word_t    rdata1,
  input  logic                wen,
  input  dpath_pkg::reg_idx_t waddr,
  input  dpath_pkg::word_t    wdata
);

  dpath_pkg::word_t regs [32];

  // No write-through, a same-cycle read sees the old value
  assign rdata0 = (raddr0 == '0) ? '0 : regs[raddr0];
  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];

  // Writes to r0 are discarded
  always_ff @(posedge clk) begin
    if (wen && waddr != '0) begin
      regs[waddr] <= wdata;
    end
  end

endmodule
